/* include/cursor_defines.svh */
`ifndef CURSOR_DEFINES_SVH
`define CURSOR_DEFINES_SVH

////////////////////////////////////////////////////////////
// 640x480 horizontal timing, in pixels
////////////////////////////////////////////////////////////
`define H_ACTIVE 640
`define H_FRONT  16
`define H_SYNC   96
`define H_TOTAL  800

////////////////////////////////////////////////////////////
// 640x480 vertical timing, in lines
////////////////////////////////////////////////////////////
`define V_ACTIVE 480
`define V_FRONT  10
`define V_SYNC   2
`define V_TOTAL  525

////////////////////////////////////////////////////////////
// cursor
////////////////////////////////////////////////////////////
`define CURSOR_SIZE 8    // side of the square box
`define START_X     320  // position after reset
`define START_Y     240

// clocks per one-pixel step
`define STEP_FAST 4
`define STEP_SLOW 16

`endif

/* logic/key_pkg.sv */
package key_pkg;

  ////////////////////////////////////////////////////////////
  // keyboard event codes
  ////////////////////////////////////////////////////////////

  // make codes set a held key and break codes clear it
  // any code that is not listed here is ignored
  typedef enum logic [7:0] {
    MAKE_UP     = 8'h75,  // up arrow
    BREAK_UP    = 8'hF5,
    MAKE_DOWN   = 8'h72,  // down arrow
    BREAK_DOWN  = 8'hF2,
    MAKE_LEFT   = 8'h6B,  // left arrow
    BREAK_LEFT  = 8'hEB,
    MAKE_RIGHT  = 8'h74,  // right arrow
    BREAK_RIGHT = 8'hF4,
    MAKE_M      = 8'h3A,  // slow-step modifier
    BREAK_M     = 8'hBA,
    MAKE_SPACE  = 8'h29,  // colour change
    BREAK_SPACE = 8'hA9
  } key_event_e;

endpackage

/* logic/video_pkg.sv */
package video_pkg;

  ////////////////////////////////////////////////////////////
  // pixel and colour types
  ////////////////////////////////////////////////////////////

  typedef logic [9:0]  coord_t;  // pixel or line index
  typedef logic [23:0] rgb_t;    // r in [23:16], g in [15:8], b in [7:0]

  // cursor colours, stepped in this order
  typedef enum logic [1:0] {
    COLOR_WHITE,
    COLOR_RED,
    COLOR_GREEN,
    COLOR_BLUE
  } cursor_color_e;

  ////////////////////////////////////////////////////////////
  // cursor palette
  ////////////////////////////////////////////////////////////

  function automatic rgb_t palette_rgb(input cursor_color_e color);
    rgb_t rgb;
    case (color)
      COLOR_WHITE: rgb = 24'hFFFFFF;
      COLOR_RED:   rgb = 24'hFF0000;
      COLOR_GREEN: rgb = 24'h00FF00;
      COLOR_BLUE:  rgb = 24'h0000FF;
      default:     rgb = 24'hFFFFFF;  // x on the input
    endcase
    return rgb;
  endfunction

endpackage

/* logic/key_event_tracker.sv */
`timescale 1ns/100ps

module key_event_tracker (
  input  logic                CLK_25MHZ,
  input  logic                reset_from_key,
  input  logic                event_ready,
  input  key_pkg::key_event_e event_code,
  output logic                hold_up,
  output logic                hold_down,
  output logic                hold_left,
  output logic                hold_right,
  output logic                hold_slow,
  output logic                color_next
);

  import key_pkg::*;

  logic hold_space;  // space currently down

  // one register per key, set by make and cleared by break
  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      hold_up    <= 1'b0;
      hold_down  <= 1'b0;
      hold_left  <= 1'b0;
      hold_right <= 1'b0;
      hold_slow  <= 1'b0;
      hold_space <= 1'b0;
      color_next <= 1'b0;
    end else begin
      color_next <= 1'b0;  // single-cycle pulse
      if (event_ready) begin
        case (event_code)
          MAKE_UP:     hold_up    <= 1'b1;
          BREAK_UP:    hold_up    <= 1'b0;
          MAKE_DOWN:   hold_down  <= 1'b1;
          BREAK_DOWN:  hold_down  <= 1'b0;
          MAKE_LEFT:   hold_left  <= 1'b1;
          BREAK_LEFT:  hold_left  <= 1'b0;
          MAKE_RIGHT:  hold_right <= 1'b1;
          BREAK_RIGHT: hold_right <= 1'b0;
          MAKE_M:      hold_slow  <= 1'b1;
          BREAK_M:     hold_slow  <= 1'b0;
          MAKE_SPACE: begin
            hold_space <= 1'b1;
            color_next <= ~hold_space;  // typematic repeats are dropped
          end
          BREAK_SPACE: hold_space <= 1'b0;
          default: ;  // other keys
        endcase
      end
    end
  end

endmodule

/* logic/cursor_mover.sv */
`timescale 1ns/100ps

`include "cursor_defines.svh"

module cursor_mover (
  input  logic                     CLK_25MHZ,
  input  logic                     reset_from_key,
  input  logic                     hold_up,
  input  logic                     hold_down,
  input  logic                     hold_left,
  input  logic                     hold_right,
  input  logic                     hold_slow,
  input  logic                     color_next,
  output video_pkg::coord_t        pointer_x,
  output video_pkg::coord_t        pointer_y,
  output video_pkg::cursor_color_e cursor_color
);

  import video_pkg::*;

  localparam coord_t X_MAX = coord_t'(`H_ACTIVE - `CURSOR_SIZE);  // last legal x
  localparam coord_t Y_MAX = coord_t'(`V_ACTIVE - `CURSOR_SIZE);  // last legal y

  logic [7:0] step_cnt;
  logic [7:0] step_last;  // final count of the current period
  logic       step_tick;
  logic       move_left;
  logic       move_right;
  logic       move_up;
  logic       move_down;

  ////////////////////////////////////////////////////////////
  // step timer
  ////////////////////////////////////////////////////////////

  assign step_last = hold_slow ? 8'(`STEP_SLOW - 1) : 8'(`STEP_FAST - 1);
  assign step_tick = (step_cnt >= step_last);  // >= covers a slow to fast switch

  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      step_cnt <= '0;
    end else if (step_tick) begin
      step_cnt <= '0;
    end else begin
      step_cnt <= step_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // position
  ////////////////////////////////////////////////////////////

  // opposite keys cancel on their axis
  assign move_left  = hold_left & ~hold_right;
  assign move_right = hold_right & ~hold_left;
  assign move_up    = hold_up & ~hold_down;
  assign move_down  = hold_down & ~hold_up;

  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      pointer_x <= coord_t'(`START_X);
      pointer_y <= coord_t'(`START_Y);
    end else if (step_tick) begin
      if (move_left && pointer_x != '0) begin
        pointer_x <= pointer_x - 1'b1;
      end else if (move_right && pointer_x < X_MAX) begin
        pointer_x <= pointer_x + 1'b1;
      end
      if (move_up && pointer_y != '0) begin  // y grows downward
        pointer_y <= pointer_y - 1'b1;
      end else if (move_down && pointer_y < Y_MAX) begin
        pointer_y <= pointer_y + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // colour
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      cursor_color <= COLOR_WHITE;
    end else if (color_next) begin
      cursor_color <= cursor_color_e'(cursor_color + 2'd1);  // wraps blue to white
    end
  end

endmodule

/* logic/raster_mixer.sv */
`timescale 1ns/100ps

`include "cursor_defines.svh"

module raster_mixer (
  input  logic                     CLK_25MHZ,
  input  logic                     reset_from_key,
  input  video_pkg::rgb_t          bg_rgb,
  input  video_pkg::coord_t        pointer_x,
  input  video_pkg::coord_t        pointer_y,
  input  video_pkg::cursor_color_e cursor_color,
  output video_pkg::rgb_t          vga_rgb,
  output logic                     vga_de,
  output logic                     vga_hs,
  output logic                     vga_vs
);

  import video_pkg::*;

  localparam coord_t H_LAST     = coord_t'(`H_TOTAL - 1);
  localparam coord_t V_LAST     = coord_t'(`V_TOTAL - 1);
  localparam coord_t HS_START   = coord_t'(`H_ACTIVE + `H_FRONT);
  localparam coord_t HS_END     = coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
  localparam coord_t VS_START   = coord_t'(`V_ACTIVE + `V_FRONT);
  localparam coord_t VS_END     = coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);
  localparam coord_t H_VISIBLE  = coord_t'(`H_ACTIVE);
  localparam coord_t V_VISIBLE  = coord_t'(`V_ACTIVE);
  localparam logic [10:0] BOX_W = 11'(`CURSOR_SIZE);

  coord_t      h_cnt;
  coord_t      v_cnt;
  logic        active;
  logic        hs_on;  // inside the sync pulse
  logic        vs_on;
  logic [10:0] box_x_end;  // one past the box, wide enough not to wrap
  logic [10:0] box_y_end;
  logic        in_box;
  rgb_t        pixel;

  ////////////////////////////////////////////////////////////
  // raster counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == H_LAST) begin
      h_cnt <= '0;
      v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;  // new frame after last line
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // decode and overlay
  ////////////////////////////////////////////////////////////

  assign active = (h_cnt < H_VISIBLE) && (v_cnt < V_VISIBLE);
  assign hs_on  = (h_cnt >= HS_START) && (h_cnt < HS_END);
  assign vs_on  = (v_cnt >= VS_START) && (v_cnt < VS_END);

  assign box_x_end = {1'b0, pointer_x} + BOX_W;
  assign box_y_end = {1'b0, pointer_y} + BOX_W;
  assign in_box    = (h_cnt >= pointer_x) && ({1'b0, h_cnt} < box_x_end) &&
                     (v_cnt >= pointer_y) && ({1'b0, v_cnt} < box_y_end);

  always_comb begin
    if (!active) begin
      pixel = '0;  // black in blanking
    end else if (in_box) begin
      pixel = palette_rgb(cursor_color);
    end else begin
      pixel = bg_rgb;
    end
  end

  // all video outputs leave on the same edge
  always_ff @(posedge CLK_25MHZ) begin
    if (reset_from_key) begin
      vga_rgb <= '0;
      vga_de  <= 1'b0;
      vga_hs  <= 1'b1;  // syncs idle high
      vga_vs  <= 1'b1;
    end else begin
      vga_rgb <= pixel;
      vga_de  <= active;
      vga_hs  <= ~hs_on;
      vga_vs  <= ~vs_on;
    end
  end

endmodule

/* logic/cursor_display_top.sv */
`timescale 1ns/100ps

module cursor_display_top (
  input  logic                CLK_25MHZ,
  input  logic                reset_from_key,
  input  logic                event_ready,
  input  key_pkg::key_event_e event_code,
  input  video_pkg::rgb_t     bg_rgb,
  output video_pkg::rgb_t     vga_rgb,
  output logic                vga_de,
  output logic                vga_hs,
  output logic                vga_vs,
  output video_pkg::coord_t   pointer_x,
  output video_pkg::coord_t   pointer_y
);

  import video_pkg::*;

  logic          hold_up;
  logic          hold_down;
  logic          hold_left;
  logic          hold_right;
  logic          hold_slow;
  logic          color_next;
  cursor_color_e cursor_color;

  ////////////////////////////////////////////////////////////
  // keyboard events to held keys
  ////////////////////////////////////////////////////////////

  key_event_tracker i_key_event_tracker (
    .CLK_25MHZ      (CLK_25MHZ),
    .reset_from_key (reset_from_key),
    .event_ready    (event_ready),
    .event_code     (event_code),
    .hold_up        (hold_up),
    .hold_down      (hold_down),
    .hold_left      (hold_left),
    .hold_right     (hold_right),
    .hold_slow      (hold_slow),
    .color_next     (color_next)
  );

  cursor_mover i_cursor_mover (
    .CLK_25MHZ      (CLK_25MHZ),
    .reset_from_key (reset_from_key),
    .hold_up        (hold_up),
    .hold_down      (hold_down),
    .hold_left      (hold_left),
    .hold_right     (hold_right),
    .hold_slow      (hold_slow),
    .color_next     (color_next),
    .pointer_x      (pointer_x),    // also exported
    .pointer_y      (pointer_y),
    .cursor_color   (cursor_color)
  );

  ////////////////////////////////////////////////////////////
  // video out
  ////////////////////////////////////////////////////////////

  raster_mixer i_raster_mixer (
    .CLK_25MHZ      (CLK_25MHZ),
    .reset_from_key (reset_from_key),
    .bg_rgb         (bg_rgb),
    .pointer_x      (pointer_x),
    .pointer_y      (pointer_y),
    .cursor_color   (cursor_color),
    .vga_rgb        (vga_rgb),
    .vga_de         (vga_de),
    .vga_hs         (vga_hs),
    .vga_vs         (vga_vs)
  );

endmodule

/* bench/tb_cursor_display.sv */
`timescale 1ns/100ps

`include "cursor_defines.svh"

module tb_cursor_display;

  import key_pkg::*;
  import video_pkg::*;

  logic       CLK_25MHZ;
  logic       reset_from_key;
  logic       event_ready;
  key_event_e event_code;
  rgb_t       bg_rgb;
  rgb_t       vga_rgb;
  logic       vga_de;
  logic       vga_hs;
  logic       vga_vs;
  coord_t     pointer_x;
  coord_t     pointer_y;

  int seed = 32'h721ff6b6;
  int err_reset = 0;
  int err_motion = 0;
  int err_pixel = 0;
  int err_raster = 0;
  int err_timeout = 0;
  int total;

  // reference model, all registered on the rising edge
  logic       was_reset = 1'b0;
  logic       checking = 1'b0;
  logic [4:0] m_hold;     // up, down, left, right, slow
  logic [4:0] used_hold;  // holds seen by the mover at the last edge
  logic       m_space;
  logic       m_bump;
  logic [1:0] m_color;
  logic [1:0] box_color;
  rgb_t       bg_d;
  int last_x, last_y, gap, steady;
  int cnt_h, cnt_v, shown_h, shown_v, box_x, box_y;
  logic hs_prev, vs_prev, de_prev, hs_seen, vs_seen, moved_once;
  int hs_gap, vs_gap, hs_low, de_run;

  cursor_display_top i_cursor_display_top (
    .CLK_25MHZ      (CLK_25MHZ),
    .reset_from_key (reset_from_key),
    .event_ready    (event_ready),
    .event_code     (event_code),
    .bg_rgb         (bg_rgb),
    .vga_rgb        (vga_rgb),
    .vga_de         (vga_de),
    .vga_hs         (vga_hs),
    .vga_vs         (vga_vs),
    .pointer_x      (pointer_x),
    .pointer_y      (pointer_y)
  );

  initial begin
    CLK_25MHZ = 1'b0;
    forever #20 CLK_25MHZ = ~CLK_25MHZ;
  end

  function automatic logic [23:0] color_to_rgb(input logic [1:0] idx);
    logic [23:0] table_rgb [4];
    table_rgb = '{24'hFFFFFF, 24'hFF0000, 24'h00FF00, 24'h0000FF};
    return table_rgb[idx];
  endfunction

  function automatic int axis_dir(input logic plus, input logic minus);
    return (plus == minus) ? 0 : (plus ? 1 : -1);
  endfunction

  function automatic int clamp(input int v, input int hi);
    return (v < 0) ? 0 : ((v > hi) ? hi : v);
  endfunction

  ////////////////////////////////////////////////////////////
  // expected values
  ////////////////////////////////////////////////////////////

  int step_len, exp_x, exp_y;
  logic moved, would_move, exp_de, in_box;
  logic hs_fall, hs_rise, vs_fall, de_fall;
  rgb_t exp_rgb;

  assign step_len   = used_hold[0] ? `STEP_SLOW : `STEP_FAST;
  assign exp_x      = clamp(last_x + axis_dir(used_hold[1], used_hold[2]),
                            `H_ACTIVE - `CURSOR_SIZE);
  assign exp_y      = clamp(last_y + axis_dir(used_hold[3], used_hold[4]),
                            `V_ACTIVE - `CURSOR_SIZE);
  assign moved      = (int'(pointer_x) != last_x) || (int'(pointer_y) != last_y);
  assign would_move = (exp_x != last_x) || (exp_y != last_y);
  assign exp_de     = (shown_h < `H_ACTIVE) && (shown_v < `V_ACTIVE);
  assign in_box     = (shown_h >= box_x) && (shown_h < box_x + `CURSOR_SIZE) &&
                      (shown_v >= box_y) && (shown_v < box_y + `CURSOR_SIZE);
  assign exp_rgb    = !exp_de ? 24'h0 : (in_box ? color_to_rgb(box_color) : bg_d);
  assign hs_fall    = hs_prev && !vga_hs;
  assign hs_rise    = !hs_prev && vga_hs;
  assign vs_fall    = vs_prev && !vga_vs;
  assign de_fall    = de_prev && !vga_de;

  always @(posedge CLK_25MHZ) begin
    was_reset <= reset_from_key;
    checking  <= !reset_from_key;
    last_x    <= int'(pointer_x);
    last_y    <= int'(pointer_y);
    box_x     <= int'(pointer_x);  // box the pixel was drawn from
    box_y     <= int'(pointer_y);
    box_color <= m_color;
    bg_d      <= bg_rgb;
    shown_h   <= cnt_h;
    shown_v   <= cnt_v;
    if (reset_from_key) begin
      m_hold <= '0;
      m_space <= 1'b0;
      m_bump <= 1'b0;
      m_color <= 2'd0;
      used_hold <= '0;
      {gap, steady, cnt_h, cnt_v, hs_gap, vs_gap, hs_low, de_run} <= '0;
      {hs_prev, vs_prev, de_prev} <= 3'b110;
      {hs_seen, vs_seen, moved_once} <= 3'b000;
    end else begin
      m_bump <= 1'b0;
      if (m_bump) begin
        m_color <= m_color + 2'd1;  // wraps to white
      end
      if (event_ready) begin
        case (event_code)
          MAKE_UP:     m_hold[4] <= 1'b1;
          BREAK_UP:    m_hold[4] <= 1'b0;
          MAKE_DOWN:   m_hold[3] <= 1'b1;
          BREAK_DOWN:  m_hold[3] <= 1'b0;
          MAKE_LEFT:   m_hold[2] <= 1'b1;
          BREAK_LEFT:  m_hold[2] <= 1'b0;
          MAKE_RIGHT:  m_hold[1] <= 1'b1;
          BREAK_RIGHT: m_hold[1] <= 1'b0;
          MAKE_M:      m_hold[0] <= 1'b1;
          BREAK_M:     m_hold[0] <= 1'b0;
          MAKE_SPACE: begin
            m_space <= 1'b1;
            m_bump  <= !m_space;  // repeats while held do nothing
          end
          BREAK_SPACE: m_space <= 1'b0;
          default: ;
        endcase
      end
      used_hold  <= m_hold;
      steady     <= (m_hold == used_hold) ? steady + 1 : 0;
      gap        <= moved ? 1 : gap + 1;  // edges since the last pointer change
      moved_once <= moved_once || moved;
      if (cnt_h == `H_TOTAL - 1) begin
        cnt_h <= 0;
        cnt_v <= (cnt_v == `V_TOTAL - 1) ? 0 : cnt_v + 1;
      end else begin
        cnt_h <= cnt_h + 1;
      end
      {hs_prev, vs_prev, de_prev} <= {vga_hs, vga_vs, vga_de};
      hs_gap  <= hs_fall ? 1 : hs_gap + 1;
      vs_gap  <= vs_fall ? 1 : vs_gap + 1;
      hs_low  <= !vga_hs ? hs_low + 1 : 0;
      de_run  <= vga_de ? de_run + 1 : 0;
      hs_seen <= hs_seen || hs_fall;
      vs_seen <= vs_seen || vs_fall;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks, sampled on the falling edge
  ////////////////////////////////////////////////////////////

  assert property (@(negedge CLK_25MHZ) !was_reset ||
      (int'(pointer_x) == `START_X && int'(pointer_y) == `START_Y &&
       vga_hs && vga_vs && !vga_de))
    else begin
      err_reset++;
      $display("FAIL %0t: reset state x=%0d y=%0d", $time, pointer_x, pointer_y);
    end

  assert property (@(negedge CLK_25MHZ) disable iff (!checking)
      (int'(pointer_x) == last_x || int'(pointer_x) == exp_x) &&
      (int'(pointer_y) == last_y || int'(pointer_y) == exp_y))
    else begin
      err_motion++;
      $display("FAIL %0t: pointer moved to %0d,%0d from %0d,%0d", $time,
               pointer_x, pointer_y, last_x, last_y);
    end

  assert property (@(negedge CLK_25MHZ) disable iff (!checking)
      (!moved || !moved_once || steady < gap || gap == step_len) &&
      (moved || !would_move || steady < 2 * step_len || gap < step_len))
    else begin
      err_motion++;
      $display("FAIL %0t: step spacing %0d, expected %0d", $time, gap, step_len);
    end

  assert property (@(negedge CLK_25MHZ) disable iff (!checking)
      vga_de == exp_de && vga_rgb == exp_rgb)
    else begin
      err_pixel++;
      $display("FAIL %0t: pixel %0d,%0d rgb=%h de=%b, expected %h", $time,
               shown_h, shown_v, vga_rgb, vga_de, exp_rgb);
    end

  assert property (@(negedge CLK_25MHZ) disable iff (!checking)
      (!hs_fall || !hs_seen || hs_gap == `H_TOTAL) && (!hs_rise || hs_low == `H_SYNC) &&
      (!vs_fall || !vs_seen || vs_gap == `H_TOTAL * `V_TOTAL) &&
      (!de_fall || de_run == `H_ACTIVE))
    else begin
      err_raster++;
      $display("FAIL %0t: raster timing hs=%0d/%0d vs=%0d de=%0d", $time,
               hs_gap, hs_low, vs_gap, de_run);
    end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic send_event(input key_event_e code);
    @(negedge CLK_25MHZ);
    event_ready = 1'b1;
    event_code  = code;
    @(negedge CLK_25MHZ);
    event_ready = 1'b0;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge CLK_25MHZ);
  endtask

  task automatic press_for(input key_event_e make_code, input key_event_e break_code);
    int cycles;
    cycles = 40 + int'($unsigned($random(seed)) % 120);
    send_event(make_code);
    idle(cycles);
    send_event(break_code);
    idle(24);
  endtask

  task automatic wait_for_x(input int target, input int limit);
    int n;
    n = 0;
    while (int'(pointer_x) != target && n < limit) begin
      @(negedge CLK_25MHZ);
      n++;
    end
    if (int'(pointer_x) != target) begin
      err_timeout++;
      $display("timeout: pointer_x did not reach %0d in %0d cycles", target, limit);
    end
  endtask

  task automatic wait_for_frame_start(input int limit);
    int   n;
    logic prev;
    logic done;
    n = 0;
    prev = vga_vs;
    done = 1'b0;
    while (!done && n < limit) begin
      @(negedge CLK_25MHZ);
      n++;
      done = prev && !vga_vs;
      prev = vga_vs;
    end
    if (!done) begin
      err_timeout++;
      $display("timeout: no vertical sync within %0d cycles", limit);
    end
  endtask

  initial begin
    event_ready    = 1'b0;
    event_code     = BREAK_SPACE;
    bg_rgb         = '0;
    reset_from_key = 1'b1;
    repeat (5) @(posedge CLK_25MHZ);
    @(negedge CLK_25MHZ);
    reset_from_key = 1'b0;
    bg_rgb = 24'($random(seed));

    press_for(MAKE_RIGHT, BREAK_RIGHT);
    press_for(MAKE_UP, BREAK_UP);
    press_for(MAKE_DOWN, BREAK_DOWN);
    press_for(MAKE_LEFT, BREAK_LEFT);
    send_event(MAKE_M);  // slow steps
    press_for(MAKE_DOWN, BREAK_DOWN);
    press_for(MAKE_RIGHT, BREAK_RIGHT);
    send_event(BREAK_M);
    send_event(MAKE_LEFT);
    send_event(MAKE_RIGHT);  // opposite keys cancel
    idle(40);
    send_event(key_event_e'(8'h1C));  // untracked key
    send_event(BREAK_LEFT);
    send_event(BREAK_RIGHT);

    // run into both x limits and sit there a while
    send_event(MAKE_LEFT);
    wait_for_x(0, 4000);
    idle(60);
    send_event(BREAK_LEFT);
    send_event(MAKE_RIGHT);
    wait_for_x(`H_ACTIVE - `CURSOR_SIZE, 4000);
    idle(60);
    send_event(BREAK_RIGHT);

    // one colour per frame, wrapping back to white
    wait_for_frame_start(900000);
    repeat (4) begin
      bg_rgb = 24'($random(seed));
      send_event(MAKE_SPACE);
      send_event(MAKE_SPACE);  // typematic repeat
      send_event(MAKE_SPACE);
      send_event(BREAK_SPACE);
      wait_for_frame_start(900000);
    end
    idle(10);

    total = err_reset + err_motion + err_pixel + err_raster + err_timeout;
    $display("errors: reset %0d, motion %0d, pixel %0d, raster %0d, timeout %0d",
             err_reset, err_motion, err_pixel, err_raster, err_timeout);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+include
logic/key_pkg.sv
logic/video_pkg.sv
logic/key_event_tracker.sv
logic/cursor_mover.sv
logic/raster_mixer.sv
logic/cursor_display_top.sv
bench/tb_cursor_display.sv

/* Makefile */
# Verilator flow for the cursor display project

VERILATOR ?= verilator
TOP       ?= tb_cursor_display
RTL_TOP   ?= cursor_display_top
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
